// File: src/pdp8_pkg.sv
//**************************************************************************
// Word types, opcode and FSM state enums, register control selects
//**************************************************************************
package pdp8_pkg;

  typedef logic [11:0] word_t;
  typedef logic [11:0] addr_t;
  typedef logic [6:0]  page_offset_t;

  localparam word_t HLT_WORD = 12'o7402;

  typedef enum logic [2:0] {
    AND, TAD, ISZ, DCA, JMS, JMP, IOT, OPR
  } opcode_t;

  typedef enum logic [5:0] {
    REG_INIT, CPU_IDLE,
    SR_CHG_1, SR_CHG_2, SR_CHG_3,
    LD_PC, LD_AC,
    DEP_1, DEP_2, DEP_3,
    FETCH_1, FETCH_2, FETCH_3, FETCH_4,
    DECODE, CAL_EA,
    EA_IND_1, EA_IND_2, EA_IND_3,
    AND_1, AND_2, AND_3, AND_4,
    TAD_1, TAD_2, TAD_3, TAD_4,
    ISZ_1, ISZ_2, ISZ_3, ISZ_4, ISZ_5, ISZ_6, ISZ_7,
    DCA_1, DCA_2, DCA_3,
    JMS_1, JMS_2, JMS_3, JMS_4,
    JMP_1, IOT_1,
    MIC_1, MIC_2, MIC_3,
    HALT
  } ctrl_state_t;

  typedef enum logic [2:0] {
    AC_NC, AC_CLR, AC_SR, AC_AND, AC_TAD, AC_CMA, AC_IAC
  } ac_ctrl_t;

  typedef enum logic [1:0] {
    LK_NC, LK_CLR, LK_CML, LK_CARRY      // Carry complements the link
  } lk_ctrl_t;

  typedef enum logic [2:0] {
    PC_NC, PC_SR, PC_P1, PC_P2, PC_JMP
  } pc_ctrl_t;

  typedef enum logic [1:0] {
    EA_NC, EA_ZP, EA_PAGE, EA_IND
  } ea_ctrl_t;

  typedef enum logic [1:0] {
    MB_NC, MB_CLR, MB_RD, MB_INC
  } mb_ctrl_t;

  typedef enum logic [1:0] {
    AD_NC, AD_PC, AD_EA, AD_SR
  } ad_sel_t;

  typedef enum logic [2:0] {
    WD_NC, WD_SR, WD_AC, WD_MB, WD_PCP1
  } wd_sel_t;

endpackage

// File: src/mem_if.sv
//**************************************************************************
// Core memory request/done interface
//**************************************************************************
`timescale 1ns/1ns

interface mem_if import pdp8_pkg::*; ();

  logic  req;       // One-cycle request strobe
  logic  write;
  addr_t addr;
  word_t wdata;
  word_t rdata;
  logic  done;      // One-cycle strobe, rdata valid here

  modport controller (
    output req, write,
    input  done
  );

  modport datapath (
    output addr, wdata,
    input  rdata, done
  );

  modport memory (
    input  req, write, addr, wdata,
    output rdata, done
  );

endinterface

// File: src/cpu_ctrl_if.sv
//**************************************************************************
// Register control selects and decode status, controller to datapath
//**************************************************************************
`timescale 1ns/1ns

interface cpu_ctrl_if import pdp8_pkg::*; ();

  ac_ctrl_t ac_ctrl;
  lk_ctrl_t lk_ctrl;
  pc_ctrl_t pc_ctrl;
  logic     ir_load;
  ea_ctrl_t ea_ctrl;
  mb_ctrl_t mb_ctrl;
  ad_sel_t  ad_sel;
  wd_sel_t  wd_sel;

  word_t    ir;
  logic     mb_zero;     // Set when MB holds zero

  modport controller (
    output ac_ctrl, lk_ctrl, pc_ctrl, ir_load,
    output ea_ctrl, mb_ctrl, ad_sel, wd_sel,
    input  ir, mb_zero
  );

  modport datapath (
    input  ac_ctrl, lk_ctrl, pc_ctrl, ir_load,
    input  ea_ctrl, mb_ctrl, ad_sel, wd_sel,
    output ir, mb_zero
  );

endinterface

// File: src/controller.sv
//**************************************************************************
// Moore FSM for front panel commands and instruction cycles
//**************************************************************************
`timescale 1ns/1ns

module controller import pdp8_pkg::*; (
  input  logic clock,
  input  logic resetN,
  input  logic run,
  input  logic step,
  input  logic srchange,
  input  logic loadpc,
  input  logic loadac,
  input  logic deposit,
  cpu_ctrl_if.controller ctrl,
  mem_if.controller mem,
  output logic cpu_idle,
  output logic halted
);

  ctrl_state_t state, next_state;
  logic        running;
  logic        pending;
  opcode_t     opcode;

  assign opcode   = opcode_t'(ctrl.ir[11:9]);
  assign cpu_idle = (state == CPU_IDLE) && !running;

  // First execute state of a memory reference instruction
  function automatic ctrl_state_t exec_state(opcode_t op);
    ctrl_state_t s;
    case (op)
      AND:     s = AND_1;
      TAD:     s = TAD_1;
      ISZ:     s = ISZ_1;
      DCA:     s = DCA_1;
      JMS:     s = JMS_1;
      default: s = JMP_1;
    endcase
    return s;
  endfunction

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) state <= REG_INIT;
    else         state <= next_state;
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      running <= 1'b0;
      halted  <= 1'b0;
    end else if (state == HALT) begin
      running <= 1'b0;
      halted  <= 1'b1;
    end else if (cpu_idle && (run || step)) begin
      running <= run;                     // Run wins over step
      halted  <= 1'b0;
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN)       pending <= 1'b0;
    else if (mem.req)  pending <= 1'b1;
    else if (mem.done) pending <= 1'b0;
  end

  always_comb begin
    next_state = state;
    case (state)
      REG_INIT: next_state = CPU_IDLE;
      CPU_IDLE: begin
        if (running)          next_state = FETCH_1;   // Keep going until HLT
        else if (run || step) next_state = FETCH_1;
        else if (srchange)    next_state = SR_CHG_1;
        else if (loadpc)      next_state = LD_PC;
        else if (loadac)      next_state = LD_AC;
        else if (deposit)     next_state = DEP_1;
      end
      SR_CHG_1: next_state = SR_CHG_2;
      SR_CHG_2: next_state = SR_CHG_3;
      SR_CHG_3: if (mem.done) next_state = CPU_IDLE;
      LD_PC:    next_state = CPU_IDLE;
      LD_AC:    next_state = CPU_IDLE;
      DEP_1:    next_state = DEP_2;
      DEP_2:    next_state = DEP_3;
      DEP_3:    if (mem.done) next_state = CPU_IDLE;
      FETCH_1:  next_state = FETCH_2;
      FETCH_2:  next_state = FETCH_3;
      FETCH_3:  if (mem.done) next_state = FETCH_4;
      FETCH_4:  next_state = DECODE;
      DECODE: begin
        if (ctrl.ir == HLT_WORD) next_state = HALT;
        else if (opcode == IOT)  next_state = IOT_1;
        else if (opcode == OPR)  next_state = MIC_1;
        else                     next_state = CAL_EA;
      end
      CAL_EA:   next_state = ctrl.ir[8] ? EA_IND_1 : exec_state(opcode);
      EA_IND_1: next_state = EA_IND_2;
      EA_IND_2: next_state = EA_IND_3;
      EA_IND_3: if (mem.done) next_state = exec_state(opcode);
      AND_1:    next_state = AND_2;
      AND_2:    next_state = AND_3;
      AND_3:    if (mem.done) next_state = AND_4;
      TAD_1:    next_state = TAD_2;
      TAD_2:    next_state = TAD_3;
      TAD_3:    if (mem.done) next_state = TAD_4;
      ISZ_1:    next_state = ISZ_2;
      ISZ_2:    next_state = ISZ_3;
      ISZ_3:    if (mem.done) next_state = ISZ_4;
      ISZ_4:    next_state = ISZ_5;
      ISZ_5:    next_state = ISZ_6;
      ISZ_6:    next_state = ISZ_7;
      ISZ_7:    if (mem.done) next_state = CPU_IDLE;
      DCA_1:    next_state = DCA_2;
      DCA_2:    next_state = DCA_3;
      DCA_3:    if (mem.done) next_state = CPU_IDLE;
      JMS_1:    next_state = JMS_2;
      JMS_2:    next_state = JMS_3;
      JMS_3:    if (mem.done) next_state = JMS_4;
      MIC_1:    next_state = MIC_2;
      MIC_2:    next_state = MIC_3;
      default:  next_state = CPU_IDLE;    // Last state of every sequence
    endcase
  end

  always_comb begin
    ctrl.ac_ctrl = AC_NC;
    ctrl.lk_ctrl = LK_NC;
    ctrl.pc_ctrl = PC_NC;
    ctrl.ir_load = 1'b0;
    ctrl.ea_ctrl = EA_NC;
    ctrl.mb_ctrl = MB_NC;
    ctrl.ad_sel  = AD_NC;
    ctrl.wd_sel  = WD_NC;
    mem.req      = 1'b0;
    mem.write    = 1'b0;
    case (state)
      REG_INIT: begin
        ctrl.ac_ctrl = AC_CLR;
        ctrl.lk_ctrl = LK_CLR;
        ctrl.mb_ctrl = MB_CLR;
      end
      SR_CHG_1: ctrl.ad_sel = AD_SR;
      LD_PC:    ctrl.pc_ctrl = PC_SR;
      LD_AC:    ctrl.ac_ctrl = AC_SR;
      DEP_1: begin
        ctrl.ad_sel = AD_PC;
        ctrl.wd_sel = WD_SR;
      end
      DEP_2: begin
        mem.req      = 1'b1;
        mem.write    = 1'b1;
        ctrl.pc_ctrl = PC_P1;             // Address already latched
      end
      FETCH_1:  ctrl.ad_sel = AD_PC;
      FETCH_4:  ctrl.ir_load = 1'b1;
      CAL_EA:   ctrl.ea_ctrl = ctrl.ir[7] ? EA_PAGE : EA_ZP;
      EA_IND_3: ctrl.ea_ctrl = EA_IND;
      SR_CHG_2, FETCH_2, EA_IND_2, AND_2, TAD_2, ISZ_2: mem.req = 1'b1;
      SR_CHG_3, FETCH_3, AND_3, TAD_3, ISZ_3:           ctrl.mb_ctrl = MB_RD;
      EA_IND_1, AND_1, TAD_1, ISZ_1:                    ctrl.ad_sel = AD_EA;
      AND_4: begin
        ctrl.ac_ctrl = AC_AND;
        ctrl.pc_ctrl = PC_P1;
      end
      TAD_4: begin
        ctrl.ac_ctrl = AC_TAD;
        ctrl.lk_ctrl = LK_CARRY;
        ctrl.pc_ctrl = PC_P1;
      end
      ISZ_4:    ctrl.mb_ctrl = MB_INC;
      ISZ_5: begin
        ctrl.wd_sel  = WD_MB;
        ctrl.pc_ctrl = ctrl.mb_zero ? PC_P2 : PC_P1;   // Skip on zero
      end
      ISZ_6, JMS_2, DCA_2: begin
        mem.req   = 1'b1;
        mem.write = 1'b1;
        if (state == JMS_2) ctrl.pc_ctrl = PC_JMP;
        if (state == DCA_2) begin
          ctrl.ac_ctrl = AC_CLR;
          ctrl.pc_ctrl = PC_P1;
        end
      end
      DCA_1: begin
        ctrl.ad_sel = AD_EA;
        ctrl.wd_sel = WD_AC;
      end
      JMS_1: begin
        ctrl.ad_sel = AD_EA;
        ctrl.wd_sel = WD_PCP1;            // Return address
      end
      JMS_4, IOT_1, HALT: ctrl.pc_ctrl = PC_P1;
      JMP_1:    ctrl.pc_ctrl = PC_JMP;
      MIC_1: if (!ctrl.ir[8]) begin
        if (ctrl.ir[7]) ctrl.ac_ctrl = AC_CLR;
        if (ctrl.ir[6]) ctrl.lk_ctrl = LK_CLR;
      end
      MIC_2: if (!ctrl.ir[8]) begin
        if (ctrl.ir[5]) ctrl.ac_ctrl = AC_CMA;
        if (ctrl.ir[4]) ctrl.lk_ctrl = LK_CML;
      end
      MIC_3: begin
        if (!ctrl.ir[8] && ctrl.ir[0]) begin
          ctrl.ac_ctrl = AC_IAC;
          ctrl.lk_ctrl = LK_CARRY;
        end
        ctrl.pc_ctrl = PC_P1;
      end
      default: ;
    endcase
  end

  // Only one memory access in flight at a time
  a_no_overlap: assert property (@(posedge clock) disable iff (!resetN)
    mem.req |-> !pending)
    else $error("Memory request issued while an access is outstanding");

endmodule

// File: src/datapath.sv
//**************************************************************************
// Datapath registers, ALU, operate logic and front panel display
//**************************************************************************
`timescale 1ns/1ns

module datapath import pdp8_pkg::*; (
  input  logic        clock,
  input  logic        resetN,
  input  word_t       switch_reg,
  input  logic [1:0]  dispsel,
  cpu_ctrl_if.datapath ctrl,
  mem_if.datapath     mem,
  output word_t       display
);

  word_t        ac;
  logic         link;
  addr_t        pc;
  word_t        ir;
  addr_t        ea;
  word_t        mb;
  addr_t        addr_q;
  word_t        wdata_q;
  page_offset_t offset;
  word_t        addend;
  logic [12:0]  sum;

  assign offset       = ir[6:0];
  assign ctrl.ir      = ir;
  assign ctrl.mb_zero = (mb == '0);
  assign mem.addr     = addr_q;
  assign mem.wdata    = wdata_q;

  // One adder for TAD and IAC, bit 12 is the carry into the link
  assign addend = (ctrl.ac_ctrl == AC_IAC) ? word_t'(1) : mb;
  assign sum    = {1'b0, ac} + {1'b0, addend};

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      ac <= '0;
    end else begin
      case (ctrl.ac_ctrl)
        AC_CLR:         ac <= '0;
        AC_SR:          ac <= switch_reg;
        AC_AND:         ac <= ac & mb;
        AC_TAD, AC_IAC: ac <= sum[11:0];
        AC_CMA:         ac <= ~ac;
        default:        ac <= ac;
      endcase
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      link <= 1'b0;
    end else begin
      case (ctrl.lk_ctrl)
        LK_CLR:   link <= 1'b0;
        LK_CML:   link <= ~link;
        LK_CARRY: link <= link ^ sum[12];
        default:  link <= link;
      endcase
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      pc <= '0;
    end else begin
      case (ctrl.pc_ctrl)
        PC_SR:   pc <= switch_reg;
        PC_P1:   pc <= pc + 12'd1;
        PC_P2:   pc <= pc + 12'd2;
        PC_JMP:  pc <= ea;
        default: pc <= pc;
      endcase
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN)           ir <= '0;
    else if (ctrl.ir_load) ir <= mb;      // MB holds the fetched word
  end

  always_ff @(posedge clock) begin
    case (ctrl.mb_ctrl)
      MB_CLR: mb <= '0;
      MB_RD:  if (mem.done) mb <= mem.rdata;
      MB_INC: mb <= mb + 12'd1;
      default: mb <= mb;
    endcase
  end

  always_ff @(posedge clock) begin
    case (ctrl.ea_ctrl)
      EA_ZP:   ea <= {5'b0, offset};
      EA_PAGE: ea <= {pc[11:7], offset};  // Page of the current instruction
      EA_IND:  if (mem.done) ea <= mem.rdata;
      default: ea <= ea;
    endcase
  end

  always_ff @(posedge clock) begin
    case (ctrl.ad_sel)
      AD_PC:   addr_q <= pc;
      AD_EA:   addr_q <= ea;
      AD_SR:   addr_q <= switch_reg;
      default: addr_q <= addr_q;
    endcase
  end

  always_ff @(posedge clock) begin
    case (ctrl.wd_sel)
      WD_SR:   wdata_q <= switch_reg;
      WD_AC:   wdata_q <= ac;
      WD_MB:   wdata_q <= mb;
      WD_PCP1: wdata_q <= pc + 12'd1;
      default: wdata_q <= wdata_q;
    endcase
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      display <= '0;
    end else begin
      case (dispsel)
        2'b00:   display <= pc;
        2'b01:   display <= ac;
        2'b10:   display <= {11'b0, link};
        default: display <= mb;
      endcase
    end
  end

  // IR only loads from a word that a fetch just brought into MB
  a_ir_after_fetch: assert property (@(posedge clock) disable iff (!resetN)
    ctrl.ir_load |-> $past(mem.done && (ctrl.mb_ctrl == MB_RD)))
    else $error("IR loaded without a completed fetch");

endmodule

// File: src/core_memory.sv
//**************************************************************************
// 4K-word core memory with fixed latency and done strobe
//**************************************************************************
`timescale 1ns/1ns

module core_memory import pdp8_pkg::*; #(
  parameter int MEM_LATENCY = 2
) (
  input logic clock,
  input logic resetN,
  mem_if.memory mem
);

  localparam int CW = $clog2(MEM_LATENCY + 1);

  word_t         ram [0:4095];
  logic [CW-1:0] count;
  addr_t         addr_q;
  word_t         wdata_q;
  logic          write_q;

  // Countdown from request to done
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN)           count <= '0;
    else if (mem.req)      count <= CW'(MEM_LATENCY);
    else if (count != '0)  count <= count - CW'(1);
  end

  always_ff @(posedge clock) begin
    if (mem.req) begin
      addr_q  <= mem.addr;
      wdata_q <= mem.wdata;
      write_q <= mem.write;
    end
  end

  always_ff @(posedge clock) begin
    if (mem.done && write_q) ram[addr_q] <= wdata_q;
  end

  assign mem.done  = (count == CW'(1));
  assign mem.rdata = ram[addr_q];

  a_done_after_req: assert property (@(posedge clock) disable iff (!resetN)
    mem.done |-> $past(mem.req, MEM_LATENCY))
    else $error("Memory done without a matching request");

endmodule

// File: src/pdp8_top.sv
//**************************************************************************
// Processor top level, controller, datapath and core memory
//**************************************************************************
`timescale 1ns/1ns

module pdp8_top import pdp8_pkg::*; #(
  parameter int MEM_LATENCY = 2           // Works from 1 to 8
) (
  input  logic       clock,
  input  logic       resetN,
  input  logic       run,
  input  logic       step,
  input  logic       srchange,
  input  logic       loadpc,
  input  logic       loadac,
  input  logic       deposit,
  input  word_t      switch_reg,
  input  logic [1:0] dispsel,
  output word_t      display,
  output logic       cpu_idle,
  output logic       halted
);

  mem_if      mem_bus ();
  cpu_ctrl_if ctrl_bus ();

  controller u_controller (
    .clock    (clock),
    .resetN   (resetN),
    .run      (run),
    .step     (step),
    .srchange (srchange),
    .loadpc   (loadpc),
    .loadac   (loadac),
    .deposit  (deposit),
    .ctrl     (ctrl_bus.controller),
    .mem      (mem_bus.controller),
    .cpu_idle (cpu_idle),
    .halted   (halted)
  );

  datapath u_datapath (
    .clock      (clock),
    .resetN     (resetN),
    .switch_reg (switch_reg),
    .dispsel    (dispsel),
    .ctrl       (ctrl_bus.datapath),
    .mem        (mem_bus.datapath),
    .display    (display)
  );

  core_memory #(
    .MEM_LATENCY (MEM_LATENCY)
  ) u_memory (
    .clock  (clock),
    .resetN (resetN),
    .mem    (mem_bus.memory)
  );

endmodule

// File: verification/tb_pdp8_model.svh
//**************************************************************************
// Reference machine model, random word source and program generator
//**************************************************************************
`ifndef TB_PDP8_MODEL_SVH
`define TB_PDP8_MODEL_SVH

integer seed = 32'h9b7d08ef;

word_t m_mem [0:4095];
word_t m_ac;
logic  m_link;
addr_t m_pc;
logic  m_halt;
word_t prog [$];

function automatic word_t rand_word();
  logic [31:0] r;
  r = $random(seed);
  return r[11:0];
endfunction

// Zero page or current page, then one level of indirection
function automatic addr_t eff_addr(word_t ir, addr_t pc);
  addr_t base;
  base = ir[7] ? {pc[11:7], ir[6:0]} : {5'b0, ir[6:0]};
  return ir[8] ? m_mem[base] : base;
endfunction

// Executes the word at m_pc on the model state
function automatic void exec_instr();
  word_t       ir;
  addr_t       ea;
  addr_t       next_pc;
  logic [12:0] sum;
  ir = m_mem[m_pc];
  ea = eff_addr(ir, m_pc);
  next_pc = m_pc + 12'd1;
  if (ir == HLT_WORD) begin
    m_halt = 1'b1;
  end else begin
    case (ir[11:9])
      3'o0: m_ac = m_ac & m_mem[ea];
      3'o1: begin
        sum = {1'b0, m_ac} + {1'b0, m_mem[ea]};
        m_ac = sum[11:0];
        m_link = m_link ^ sum[12];
      end
      3'o2: begin
        m_mem[ea] = m_mem[ea] + 12'd1;
        if (m_mem[ea] == 12'd0) next_pc = m_pc + 12'd2;   // Skip on zero
      end
      3'o3: begin
        m_mem[ea] = m_ac;
        m_ac = 12'd0;
      end
      3'o4: begin
        m_mem[ea] = m_pc + 12'd1;
        next_pc = ea + 12'd1;
      end
      3'o5: next_pc = ea;
      3'o7: if (!ir[8]) begin
        if (ir[7]) m_ac = 12'd0;
        if (ir[6]) m_link = 1'b0;
        if (ir[5]) m_ac = ~m_ac;
        if (ir[4]) m_link = ~m_link;
        if (ir[0]) begin
          sum = {1'b0, m_ac} + 13'd1;
          m_ac = sum[11:0];
          m_link = m_link ^ sum[12];
        end
      end
      default: ;                          // IOT and group 2 act as no-ops
    endcase
  end
  m_pc = next_pc;
endfunction

// Random AND..JMP placed at pc, indirect only through a pointer into 0000-0377
function automatic word_t gen_mri(addr_t pc);
  word_t w;
  addr_t base;
  w = rand_word();
  if (w[11:9] > 3'd5) w[11:9] = w[11:9] - 3'd6;
  base = w[7] ? {pc[11:7], w[6:0]} : {5'b0, w[6:0]};
  if (w[8] && (base == pc || m_mem[base] >= 12'o400)) w[8] = 1'b0;
  return w;
endfunction

function automatic word_t gen_operate();
  word_t w;
  w = rand_word();
  return {3'o7, 1'b0, w[7:4], 3'b000, w[0]};
endfunction

// Straight-line body at 0200, then JMS 0300 and HLT
function automatic void gen_program(int n);
  word_t w;
  prog.delete();
  for (int i = 0; i < n; i++) begin
    w = rand_word();
    if (w[2:0] == 3'd0) prog.push_back({3'o7, 1'b0, w[7:4], 3'b000, w[3]});
    else prog.push_back({1'b0, w[10:9], w[8], 1'b0, w[8], w[5:0]});
  end
  prog.push_back(12'o4300);
  prog.push_back(HLT_WORD);
endfunction

`endif

// File: verification/tb_pdp8.sv
//**************************************************************************
// Testbench for the processor top level with reference model compare
//**************************************************************************
`timescale 1ns/1ns

module tb_pdp8 import pdp8_pkg::*; ();

  localparam int TIMEOUT = 20000;
  localparam int C_RUN = 0, C_STEP = 1, C_SRCHG = 2, C_LDPC = 3, C_LDAC = 4, C_DEP = 5;

  logic       clock, resetN, run, step, srchange, loadpc, loadac, deposit;
  word_t      switch_reg;
  logic [1:0] dispsel;
  word_t      display;
  logic       cpu_idle, halted;
  word_t      v;

  `include "tb_pdp8_model.svh"

  pdp8_top uut (
    .clock (clock), .resetN (resetN), .run (run), .step (step),
    .srchange (srchange), .loadpc (loadpc), .loadac (loadac), .deposit (deposit),
    .switch_reg (switch_reg), .dispsel (dispsel), .display (display),
    .cpu_idle (cpu_idle), .halted (halted)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  task automatic check_value(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      $display("Test FAILED");
      $fatal(1, "Stopped at first error");
    end
  endtask

  task automatic wait_idle(input string what);
    int n;
    n = 0;
    while (!cpu_idle && n < TIMEOUT) begin
      @(negedge clock);
      n++;
    end
    if (!cpu_idle) begin
      $display("Timeout: cpu_idle did not return after %s", what);
      $display("Test FAILED");
      $fatal(1, "Stopped on timeout");
    end
  endtask

  // One-cycle strobe, switch value held until the command ends
  task automatic issue(input int cmd, input word_t sw, input string what);
    @(negedge clock);
    switch_reg = sw;
    run      = (cmd == C_RUN);
    step     = (cmd == C_STEP);
    srchange = (cmd == C_SRCHG);
    loadpc   = (cmd == C_LDPC);
    loadac   = (cmd == C_LDAC);
    deposit  = (cmd == C_DEP);
    @(negedge clock);
    {run, step, srchange, loadpc, loadac, deposit} = '0;
    wait_idle(what);
  endtask

  task automatic read_display(input logic [1:0] sel, output word_t val);
    @(negedge clock);
    dispsel = sel;
    @(negedge clock);
    val = display;
  endtask

  task automatic check_regs();
    word_t d;
    read_display(2'b00, d);
    check_value("pc", d, m_pc);
    read_display(2'b01, d);
    check_value("ac", d, m_ac);
    read_display(2'b10, d);
    check_value("link", d, {11'b0, m_link});
    check_value("halted", {11'b0, halted}, {11'b0, m_halt});
  endtask

  task automatic load_pc(input word_t a);
    issue(C_LDPC, a, "loadpc");
    m_pc = a;
    check_regs();
  endtask

  task automatic load_ac(input word_t a);
    issue(C_LDAC, a, "loadac");
    m_ac = a;
    check_regs();
  endtask

  task automatic deposit_word(input word_t w);
    issue(C_DEP, w, "deposit");
    m_mem[m_pc] = w;
    m_pc = m_pc + 12'd1;
    check_regs();
  endtask

  task automatic examine_word(input addr_t a);
    word_t d;
    issue(C_SRCHG, a, "srchange");
    read_display(2'b11, d);
    check_value("mb", d, m_mem[a]);
    check_regs();
  endtask

  task automatic step_instr();
    issue(C_STEP, switch_reg, "step");
    m_halt = 1'b0;
    exec_instr();
    check_regs();
  endtask

  task automatic run_program();
    int n;
    m_halt = 1'b0;
    n = 0;
    while (!m_halt && n < 1000) begin
      exec_instr();
      n++;
    end
    if (!m_halt) begin
      $display("Reference model did not reach HLT in the generated program");
      $display("Test FAILED");
      $fatal(1, "Stopped on model error");
    end
    issue(C_RUN, switch_reg, "run");
    check_regs();
  endtask

  // Keep PC inside page 1 so every operand stays in 0000-0377
  task automatic park_pc();
    word_t r;
    r = rand_word();
    if (m_pc < 12'o200 || m_pc > 12'o377) load_pc({5'b00001, r[6:0]});
  endtask

  task automatic step_word(input word_t w);
    addr_t a;
    a = m_pc;
    deposit_word(w);
    load_pc(a);
    step_instr();
  endtask

  initial begin
    addr_t base;
    {run, step, srchange, loadpc, loadac, deposit} = '0;
    switch_reg = '0;
    dispsel = 2'b00;
    resetN = 1'b0;
    m_ac = '0;
    m_link = 1'b0;
    m_pc = '0;
    m_halt = 1'b0;
    repeat (16) @(negedge clock);
    resetN = 1'b1;
    @(negedge clock);                     // One cycle in REG_INIT
    check_value("cpu_idle", {11'b0, cpu_idle}, 12'd1);
    check_regs();
    read_display(2'b11, v);
    check_value("mb", v, 12'd0);

    repeat (8) begin
      load_pc(rand_word());
      load_ac(rand_word());
    end

    base = rand_word();
    load_pc(base);
    repeat (16) deposit_word(rand_word());
    for (int i = 0; i < 16; i++) examine_word(base + 12'(i));

    load_pc(12'o0);
    repeat (256) deposit_word(rand_word());
    repeat (200) begin
      park_pc();
      step_word(gen_mri(m_pc));
    end

    repeat (40) begin
      park_pc();
      load_ac(rand_word());
      step_word(gen_operate());
    end

    // Data at 0000-0077, pointers into it at 0100-0177
    load_pc(12'o0);
    for (int i = 0; i < 128; i++) begin
      v = rand_word();
      deposit_word((i < 64) ? v : (v & 12'o77));
    end
    gen_program(40);
    load_pc(12'o200);
    foreach (prog[i]) deposit_word(prog[i]);
    load_pc(12'o300);
    deposit_word(12'o0);
    deposit_word(HLT_WORD);
    load_pc(12'o200);
    run_program();
    check_value("halted", {11'b0, halted}, 12'd1);
    for (int i = 0; i < 64; i++) examine_word(12'(i));
    examine_word(12'o300);

    $display("Test OK");
    $finish;
  end

endmodule

// File: sim.f
+incdir+verification
src/pdp8_pkg.sv
src/mem_if.sv
src/cpu_ctrl_if.sv
src/controller.sv
src/datapath.sv
src/core_memory.sv
src/pdp8_top.sv
verification/tb_pdp8.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the processor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_pdp8 -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/Vtb_pdp8
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0
